// ==== logic/ps2_macros.svh ====
/*
 * PS/2 frame format, prefix bytes and status register layout.
 * Values follow the PS/2 scan code set 2 standard and are not meant to change.
 */

`ifndef PS2_MACROS_SVH
`define PS2_MACROS_SVH

// start + 8 data bits (LSB first) + odd parity + stop
`define PS2_FRAME_BITS      11

// prefix bytes of scan code set 2
`define PS2_BREAK_CODE      8'hF0
`define PS2_EXTEND_CODE     8'hE0

// left and right shift make codes
`define PS2_LSHIFT_CODE     8'h12
`define PS2_RSHIFT_CODE     8'h59

// status byte bit positions, all other bits read zero
`define STAT_READY_BIT      7
`define STAT_FRAME_ERR_BIT  6
`define STAT_OVERRUN_BIT    5

`endif

// ==== logic/ps2_frame_pkg.sv ====
/*
 * Line-level types of the PS/2 receiver.
 * ps2_frame_t lives in the key_clk domain and is only sampled in clk25
 * when the toggle flag announces a finished frame.
 */

`default_nettype none

package ps2_frame_pkg;

    // one checked frame as captured on key_clk
    typedef struct packed
    {
        // data byte, bits 1..8 of the frame
        logic [7:0] code;
        // start 0, stop 1 and odd parity all held
        logic       frame_ok;
    } ps2_frame_t;

    // one received scan byte in the clk25 domain
    typedef struct packed
    {
        // one-cycle pulse, no back-pressure
        logic       valid;
        logic [7:0] code;
    } scan_byte_t;

endpackage

`default_nettype wire

// ==== logic/key_event_pkg.sv ====
/*
 * Event-level types: decoder states, key event opcodes and the
 * translated character. All valids are one-cycle pulses in clk25.
 */

`default_nettype none

package key_event_pkg;

    // prefix tracking of the scan code decoder
    typedef enum logic [1:0]
    {
        ST_NORMAL,
        ST_BREAK,
        ST_EXTEND,
        ST_EXT_BREAK
    } decode_state_e;

    // kind of key event
    typedef enum logic [1:0]
    {
        OP_MAKE,
        OP_BREAK,
        OP_EXT_MAKE,
        OP_EXT_BREAK
    } key_op_e;

    typedef struct packed
    {
        logic       valid;
        key_op_e    op;
        // scan code with the prefixes stripped
        logic [7:0] code;
    } key_event_t;

    typedef struct packed
    {
        logic       valid;
        logic [7:0] ascii;
    } char_t;

endpackage

`default_nettype wire

// ==== logic/ps2_frame_receiver.sv ====
/*
 * Receive-only PS/2 frame receiver. Assumes the device drives data while
 * key_clk is low and that frames are spaced far enough apart for the
 * toggle crossing (at least a few clk25 cycles). No resync on a lost bit.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ps2_macros.svh"

module ps2_frame_receiver
(
    input  wire logic                     clk25,
    input  wire logic                     reset,
    input  wire logic                     key_clk,
    input  wire logic                     key_din,
    output ps2_frame_pkg::scan_byte_t     scan,
    output logic                          frame_error
);

    import ps2_frame_pkg::*;

    // key_clk domain
    logic [3:0]                   bit_cnt;
    // first ten bits of the frame, newest bit on top
    logic [`PS2_FRAME_BITS-2:0]   shift_q;
    // complete frame including the bit on the current edge
    logic [`PS2_FRAME_BITS-1:0]   frame_bits;
    ps2_frame_t                   frame_q;
    logic                         rx_toggle;

    // clk25 domain
    logic                         toggle_sync1;
    logic                         toggle_sync2;
    logic                         toggle_seen;
    logic                         frame_pulse;

    assign frame_bits = {key_din, shift_q};

    // data is stable while key_clk is low, so sample on the rising edge
    always_ff @(posedge key_clk or posedge reset)
    begin
        if (reset)
        begin
            bit_cnt   <= '0;
            rx_toggle <= 1'b0;
        end
        else if (bit_cnt == 4'(`PS2_FRAME_BITS - 1))
        begin
            // 11th edge, frame done
            bit_cnt   <= '0;
            rx_toggle <= ~rx_toggle;
        end
        else
        begin
            bit_cnt <= bit_cnt + 4'd1;
        end
    end

    always_ff @(posedge key_clk)
    begin
        // LSB first, so shift towards bit 0
        shift_q <= frame_bits[`PS2_FRAME_BITS-1:1];
        if (bit_cnt == 4'(`PS2_FRAME_BITS - 1))
        begin
            frame_q.code     <= frame_bits[8:1];
            // start low, stop high, data plus parity has odd weight
            frame_q.frame_ok <= ~frame_bits[0] & frame_bits[10] & (^frame_bits[9:1]);
        end
    end

    // two-flop synchronizer plus edge register on the toggle
    always_ff @(posedge clk25 or posedge reset)
    begin
        if (reset)
        begin
            toggle_sync1 <= 1'b0;
            toggle_sync2 <= 1'b0;
            toggle_seen  <= 1'b0;
        end
        else
        begin
            toggle_sync1 <= rx_toggle;
            toggle_sync2 <= toggle_sync1;
            toggle_seen  <= toggle_sync2;
        end
    end

    assign frame_pulse = toggle_sync2 ^ toggle_seen;

    // frame_q has been stable for many clk25 cycles when the pulse fires
    always_ff @(posedge clk25 or posedge reset)
    begin
        if (reset)
        begin
            scan        <= '0;
            frame_error <= 1'b0;
        end
        else
        begin
            scan.valid  <= frame_pulse & frame_q.frame_ok;
            frame_error <= frame_pulse & ~frame_q.frame_ok;
            if (frame_pulse)
                scan.code <= frame_q.code;
        end
    end

endmodule

`default_nettype wire

// ==== logic/scancode_decoder.sv ====
/*
 * Folds F0 and E0 prefixes of scan code set 2 into key events.
 * One event per complete sequence, one cycle after its last byte.
 * Pause/Print Screen multi-byte sequences are not special-cased.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ps2_macros.svh"

module scancode_decoder
(
    input  wire logic                     clk25,
    input  wire logic                     reset,
    input  ps2_frame_pkg::scan_byte_t     scan,
    output key_event_pkg::key_event_t     key_event
);

    import key_event_pkg::*;

    decode_state_e  state_q;
    decode_state_e  state_n;
    key_event_t     event_n;

    always_comb
    begin
        state_n         = state_q;
        // nothing emitted unless a sequence completes
        event_n.valid   = 1'b0;
        event_n.op      = OP_MAKE;
        event_n.code    = scan.code;

        if (scan.valid)
        begin
            case (state_q)
                ST_NORMAL:
                begin
                    if (scan.code == `PS2_BREAK_CODE)
                        state_n = ST_BREAK;
                    else if (scan.code == `PS2_EXTEND_CODE)
                        state_n = ST_EXTEND;
                    else
                        event_n.valid = 1'b1;
                end
                ST_BREAK:
                begin
                    // released plain key
                    event_n.valid = 1'b1;
                    event_n.op    = OP_BREAK;
                    state_n       = ST_NORMAL;
                end
                ST_EXTEND:
                begin
                    if (scan.code == `PS2_BREAK_CODE)
                    begin
                        state_n = ST_EXT_BREAK;
                    end
                    else
                    begin
                        event_n.valid = 1'b1;
                        event_n.op    = OP_EXT_MAKE;
                        state_n       = ST_NORMAL;
                    end
                end
                ST_EXT_BREAK:
                begin
                    // E0 F0 xx
                    event_n.valid = 1'b1;
                    event_n.op    = OP_EXT_BREAK;
                    state_n       = ST_NORMAL;
                end
                default:
                    state_n = ST_NORMAL;
            endcase
        end
    end

    always_ff @(posedge clk25 or posedge reset)
    begin
        if (reset)
        begin
            state_q   <= ST_NORMAL;
            key_event <= '0;
        end
        else
        begin
            state_q   <= state_n;
            key_event <= event_n;
        end
    end

endmodule

`default_nettype wire

// ==== logic/keymap_translator.sv ====
/*
 * US layout, plain make codes only. Shift changes letters only; no caps
 * lock, no shifted symbols and no characters for extended keys.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ps2_macros.svh"

module keymap_translator
(
    input  wire logic                     clk25,
    input  wire logic                     reset,
    input  key_event_pkg::key_event_t     key_event,
    output key_event_pkg::char_t          char
);

    import key_event_pkg::*;

    logic   lshift;
    logic   rshift;
    char_t  char_n;

    // US table, letters lowercase, valid low for unmapped codes
    function automatic char_t us_lookup(input logic [7:0] code);
        char_t c;
        c.valid = 1'b1;
        case (code)
            8'h1C: c.ascii = "a";
            8'h32: c.ascii = "b";
            8'h21: c.ascii = "c";
            8'h23: c.ascii = "d";
            8'h24: c.ascii = "e";
            8'h2B: c.ascii = "f";
            8'h34: c.ascii = "g";
            8'h33: c.ascii = "h";
            8'h43: c.ascii = "i";
            8'h3B: c.ascii = "j";
            8'h42: c.ascii = "k";
            8'h4B: c.ascii = "l";
            8'h3A: c.ascii = "m";
            8'h31: c.ascii = "n";
            8'h44: c.ascii = "o";
            8'h4D: c.ascii = "p";
            8'h15: c.ascii = "q";
            8'h2D: c.ascii = "r";
            8'h1B: c.ascii = "s";
            8'h2C: c.ascii = "t";
            8'h3C: c.ascii = "u";
            8'h2A: c.ascii = "v";
            8'h1D: c.ascii = "w";
            8'h22: c.ascii = "x";
            8'h35: c.ascii = "y";
            8'h1A: c.ascii = "z";
            8'h45: c.ascii = "0";
            8'h16: c.ascii = "1";
            8'h1E: c.ascii = "2";
            8'h26: c.ascii = "3";
            8'h25: c.ascii = "4";
            8'h2E: c.ascii = "5";
            8'h36: c.ascii = "6";
            8'h3D: c.ascii = "7";
            8'h3E: c.ascii = "8";
            8'h46: c.ascii = "9";
            8'h4E: c.ascii = "-";
            8'h55: c.ascii = "=";
            // backslash
            8'h5D: c.ascii = 8'h5C;
            8'h54: c.ascii = "[";
            8'h5B: c.ascii = "]";
            8'h52: c.ascii = "'";
            8'h41: c.ascii = ",";
            8'h49: c.ascii = ".";
            8'h4A: c.ascii = "/";
            8'h29: c.ascii = 8'h20;
            // backspace and enter
            8'h66: c.ascii = 8'h08;
            8'h5A: c.ascii = 8'h0D;
            default:
            begin
                c.valid = 1'b0;
                c.ascii = 8'h00;
            end
        endcase
        return c;
    endfunction

    always_comb
    begin
        char_n = us_lookup(key_event.code);
        // only plain makes produce a character
        if (!(key_event.valid && key_event.op == OP_MAKE))
            char_n.valid = 1'b0;
        // either shift held turns a-z into A-Z
        if ((lshift || rshift) && char_n.ascii >= "a" && char_n.ascii <= "z")
            char_n.ascii = char_n.ascii - 8'h20;
    end

    always_ff @(posedge clk25 or posedge reset)
    begin
        if (reset)
        begin
            lshift <= 1'b0;
            rshift <= 1'b0;
            char   <= '0;
        end
        else
        begin
            char <= char_n;
            if (key_event.valid && key_event.code == `PS2_LSHIFT_CODE)
            begin
                if (key_event.op == OP_MAKE)
                    lshift <= 1'b1;
                else if (key_event.op == OP_BREAK)
                    lshift <= 1'b0;
            end
            if (key_event.valid && key_event.code == `PS2_RSHIFT_CODE)
            begin
                if (key_event.op == OP_MAKE)
                    rshift <= 1'b1;
                else if (key_event.op == OP_BREAK)
                    rshift <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/key_register_port.sv ====
/*
 * One-character receive register for the CPU bus. Address 0 reads the
 * character, address 1 the status byte. A character that arrives before
 * the previous one is read overwrites it and sets overrun.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ps2_macros.svh"

module key_register_port
(
    input  wire logic                 clk25,
    input  wire logic                 reset,
    input  key_event_pkg::char_t      char,
    input  wire logic                 frame_error,
    input  wire logic                 cs,
    input  wire logic                 address,
    output logic [7:0]                dout
);

    logic [7:0]  char_q;
    logic        ready;
    logic        overrun;
    logic        frame_err_flag;
    logic [7:0]  status;
    logic        read_data;
    logic        read_status;

    assign read_data   = cs & ~address;
    assign read_status = cs & address;

    always_comb
    begin
        status                      = 8'h00;
        status[`STAT_READY_BIT]     = ready;
        status[`STAT_FRAME_ERR_BIT] = frame_err_flag;
        status[`STAT_OVERRUN_BIT]   = overrun;
    end

    always_ff @(posedge clk25 or posedge reset)
    begin
        if (reset)
        begin
            char_q         <= 8'h00;
            ready          <= 1'b0;
            overrun        <= 1'b0;
            frame_err_flag <= 1'b0;
            dout           <= 8'h00;
        end
        else
        begin
            if (char.valid)
                char_q <= char.ascii;
            // a new character wins over a clearing read
            ready          <= char.valid | (ready & ~read_data);
            // lost only if the old character was still unread
            overrun        <= ~read_data & (overrun | (char.valid & ready));
            frame_err_flag <= frame_error | (frame_err_flag & ~read_status);
            // dout holds when cs is low
            if (cs)
                dout <= address ? status : char_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ps2_keyboard_top.sv ====
/*
 * PS/2 keyboard receiver for an 8-bit I/O bus on clk25.
 * Receive only: no commands or LED updates are sent to the keyboard.
 */

`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_top
(
    input  wire logic        clk25,
    input  wire logic        reset,
    input  wire logic        key_clk,
    input  wire logic        key_din,
    input  wire logic        cs,
    input  wire logic        address,
    output logic [7:0]       dout
);

    import ps2_frame_pkg::*;
    import key_event_pkg::*;

    // receiver to decoder
    scan_byte_t  scan;
    logic        frame_error;
    // decoder to translator
    key_event_t  key_event;
    // translator to register port
    char_t       char;

    ps2_frame_receiver u_receiver
    (
        .clk25       (clk25),
        .reset       (reset),
        .key_clk     (key_clk),
        .key_din     (key_din),
        .scan        (scan),
        .frame_error (frame_error)
    );

    scancode_decoder u_decoder
    (
        .clk25     (clk25),
        .reset     (reset),
        .scan      (scan),
        .key_event (key_event)
    );

    keymap_translator u_translator
    (
        .clk25     (clk25),
        .reset     (reset),
        .key_event (key_event),
        .char      (char)
    );

    key_register_port u_register_port
    (
        .clk25       (clk25),
        .reset       (reset),
        .char        (char),
        .frame_error (frame_error),
        .cs          (cs),
        .address     (address),
        .dout        (dout)
    );

endmodule

`default_nettype wire

// ==== verification/ps2_keyboard_sva.sv ====
/*
 * Concurrent checks on the CPU register port, bound into every
 * key_register_port instance. Checks are off while reset is high.
 */

`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_sva
(
    input  wire logic              clk25,
    input  wire logic              reset,
    input  key_event_pkg::char_t   char,
    input  wire logic              cs,
    input  wire logic              address,
    input  wire logic              ready,
    input  wire logic [7:0]        dout
);

    // number of failed assertions so far
    int failures = 0;

    // a data read with no new character drops ready
    assert property (@(posedge clk25) disable iff (reset)
        (cs && !address && !char.valid) |=> !ready)
    else
    begin
        $error("ready still set after a data read");
        failures++;
    end

    // dout holds while the port is not selected
    assert property (@(posedge clk25) disable iff (reset)
        !cs |=> $stable(dout))
    else
    begin
        $error("dout changed without cs");
        failures++;
    end

    // an arriving character always raises ready
    assert property (@(posedge clk25) disable iff (reset)
        char.valid |=> ready)
    else
    begin
        $error("ready not set after char valid");
        failures++;
    end

endmodule

bind key_register_port ps2_keyboard_sva u_sva
(
    .clk25   (clk25),
    .reset   (reset),
    .char    (char),
    .cs      (cs),
    .address (address),
    .ready   (ready),
    .dout    (dout)
);

`default_nettype wire

// ==== verification/ps2_keyboard_tb.sv ====
/*
 * Testbench of the PS/2 keyboard receiver. Frames are bit-banged on key_clk
 * with a bit time of 20 clk25 cycles; results are read back through the bus
 * port and checked against a US-layout model with shift and flag tracking.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ps2_macros.svh"

module ps2_keyboard_tb;

    localparam int CLK_PERIOD = 8;
    localparam int BIT_CYCLES = 20;
    localparam int SETTLE     = 20;
    localparam int QUIET_WAIT = 200;
    localparam int MAX_POLLS  = 100;
    localparam int MAP_SIZE   = 48;
    localparam int LETTERS    = 26;
    // test lengths
    localparam int N_PLAIN    = 12;
    localparam int N_SHIFTED  = 6;
    localparam int N_AFTER    = 3;
    localparam int N_SEQ      = 3;
    localparam int TOTAL_FRAMES = N_PLAIN + (3 + N_SHIFTED + N_AFTER) + (N_SEQ * 7 + 9) + 2 + 2;
    // frames times bit times times a margin of 4
    localparam int WATCHDOG_NS =
        TOTAL_FRAMES * `PS2_FRAME_BITS * BIT_CYCLES * CLK_PERIOD * 4;

    // US table in the order of the character string
    // entry 0 sits in the top byte of both vectors
    localparam logic [8*MAP_SIZE-1:0] MAP_CODES = {
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A,
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46,
        8'h4E, 8'h55, 8'h5D, 8'h54, 8'h5B, 8'h52, 8'h41, 8'h49, 8'h4A,
        8'h29, 8'h66, 8'h5A
    };
    localparam logic [8*MAP_SIZE-1:0] MAP_CHARS = {
        "abcdefghijklmnopqrstuvwxyz0123456789-=\\[]',./", 8'h20, 8'h08, 8'h0D
    };

    logic        clk25;
    logic        reset;
    logic        key_clk;
    logic        key_din;
    logic        cs;
    logic        address;
    logic [7:0]  dout;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          tests;
    // model state
    logic        exp_ready;
    logic        exp_overrun;
    logic        exp_frame_err;
    logic [7:0]  exp_char;
    logic        exp_lshift;
    logic        exp_rshift;

    ps2_keyboard_top UUT
    (
        .clk25   (clk25),
        .reset   (reset),
        .key_clk (key_clk),
        .key_din (key_din),
        .cs      (cs),
        .address (address),
        .dout    (dout)
    );

    initial
    begin
        clk25 = 1'b0;
        forever #(CLK_PERIOD / 2) clk25 = ~clk25;
    end

    // ends a run that stops making progress
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift32(rng);
        return int'(rng % n);
    endfunction

    function automatic logic [7:0] table_code(input int idx);
        return MAP_CODES[8*(MAP_SIZE-1-idx) +: 8];
    endfunction

    // character the keyboard should produce for table entry idx
    // shift only changes the 26 letters at the start of the table
    function automatic logic [7:0] expected_char(input int idx);
        logic [7:0] c;
        c = MAP_CHARS[8*(MAP_SIZE-1-idx) +: 8];
        if ((exp_lshift || exp_rshift) && idx < LETTERS)
            c = 8'h41 + 8'(idx);
        return c;
    endfunction

    function automatic logic [7:0] status_word();
        logic [7:0] s;
        s = 8'h00;
        s[`STAT_READY_BIT]     = exp_ready;
        s[`STAT_FRAME_ERR_BIT] = exp_frame_err;
        s[`STAT_OVERRUN_BIT]   = exp_overrun;
        return s;
    endfunction

    // every task starts and ends 1 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk25);
        #1;
    endtask

    // frame is start, data LSB first, odd parity and stop
    // the device changes data while key_clk is low
    task automatic send_frame(input logic [7:0] code, input logic bad_parity,
                              input logic bad_stop);
        logic [10:0] bits;
        int          i;
        bits = {~bad_stop, (~^code) ^ bad_parity, code, 1'b0};
        for (i = 0; i < `PS2_FRAME_BITS; i++)
        begin
            key_clk = 1'b0;
            key_din = bits[i];
            wait_cycles(BIT_CYCLES / 2);
            key_clk = 1'b1;
            wait_cycles(BIT_CYCLES / 2);
        end
        key_din = 1'b1;
        wait_cycles(SETTLE);
    endtask

    task automatic send_byte(input logic [7:0] code);
        send_frame(code, 1'b0, 1'b0);
    endtask

    // pulses cs for one cycle and samples dout in the following cycle
    task automatic read_reg(input logic adr, output logic [7:0] value);
        cs      = 1'b1;
        address = adr;
        wait_cycles(1);
        cs      = 1'b0;
        value   = dout;
    endtask

    task automatic check_read(input logic adr, input logic [7:0] expected,
                              input string name);
        logic [7:0] value;
        read_reg(adr, value);
        checks++;
        assert (value === expected)
        else
        begin
            $display("[ERROR] dout (%s read): got %h, expected %h", name, value, expected);
            errors++;
        end
        // side effects of the read on the flags
        if (adr)
            exp_frame_err = 1'b0;
        else
        begin
            exp_ready   = 1'b0;
            exp_overrun = 1'b0;
        end
    endtask

    // read status until the given bit shows, then compare the whole byte
    task automatic poll_status(input int bit_pos);
        logic [7:0] value;
        int         polls;
        value = 8'h00;
        polls = 0;
        while (!value[bit_pos] && polls < MAX_POLLS)
        begin
            read_reg(1'b1, value);
            polls++;
        end
        checks++;
        assert (value[bit_pos])
        else
        begin
            $display("status bit %0d never came up within %0d reads", bit_pos, MAX_POLLS);
            errors++;
        end
        if (value[bit_pos])
        begin
            assert (value === status_word())
            else
            begin
                $display("[ERROR] dout (status poll): got %h, expected %h",
                         value, status_word());
                errors++;
            end
        end
        exp_frame_err = 1'b0;
    endtask

    // sends a mapped make code and records the character it should give
    task automatic press_key(input int idx);
        send_byte(table_code(idx));
        if (exp_ready)
            exp_overrun = 1'b1;
        exp_ready = 1'b1;
        exp_char  = expected_char(idx);
    endtask

    task automatic type_and_read(input int idx);
        press_key(idx);
        poll_status(`STAT_READY_BIT);
        check_read(1'b0, exp_char, "data");
        check_read(1'b1, status_word(), "status");
    endtask

    // for sequences that must not produce a character
    task automatic expect_quiet();
        wait_cycles(QUIET_WAIT);
        check_read(1'b1, status_word(), "status");
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - start_errors);
    endtask

    initial
    begin
        int          start;
        int          i;
        logic [7:0]  shift_code;
        logic [7:0]  quiet_codes [3];

        // all DUT inputs idle with both PS/2 lines high
        reset   = 1'b1;
        key_clk = 1'b1;
        key_din = 1'b1;
        cs      = 1'b0;
        address = 1'b0;
        rng     = 32'd42;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        exp_ready     = 1'b0;
        exp_overrun   = 1'b0;
        exp_frame_err = 1'b0;
        exp_char      = 8'h00;
        exp_lshift    = 1'b0;
        exp_rshift    = 1'b0;
        quiet_codes   = '{8'h76, 8'h05, 8'h0D};
        repeat (4) @(posedge clk25);
        #1;
        reset = 1'b0;
        wait_cycles(2);

        start = errors;
        check_read(1'b1, 8'h00, "status");
        check_read(1'b0, 8'h00, "data");
        end_test("reset values", start);

        start = errors;
        for (i = 0; i < N_PLAIN; i++)
            type_and_read(rand_below(MAP_SIZE));
        end_test("random make codes", start);

        // shift held for a few letters, then released
        start = errors;
        shift_code = rand_below(2) ? `PS2_RSHIFT_CODE : `PS2_LSHIFT_CODE;
        send_byte(shift_code);
        exp_lshift = (shift_code == `PS2_LSHIFT_CODE);
        exp_rshift = (shift_code == `PS2_RSHIFT_CODE);
        for (i = 0; i < N_SHIFTED; i++)
            type_and_read(rand_below(LETTERS));
        send_byte(`PS2_BREAK_CODE);
        send_byte(shift_code);
        exp_lshift = 1'b0;
        exp_rshift = 1'b0;
        for (i = 0; i < N_AFTER; i++)
            type_and_read(rand_below(LETTERS));
        end_test("shifted letters", start);

        start = errors;
        for (i = 0; i < N_SEQ; i++)
        begin
            send_byte(`PS2_BREAK_CODE);
            send_byte(table_code(rand_below(MAP_SIZE)));
            expect_quiet();
            send_byte(`PS2_EXTEND_CODE);
            send_byte(table_code(rand_below(MAP_SIZE)));
            expect_quiet();
            send_byte(`PS2_EXTEND_CODE);
            send_byte(`PS2_BREAK_CODE);
            send_byte(table_code(rand_below(MAP_SIZE)));
            expect_quiet();
        end
        // shift press and release alone give nothing
        send_byte(`PS2_LSHIFT_CODE);
        expect_quiet();
        send_byte(`PS2_BREAK_CODE);
        send_byte(`PS2_LSHIFT_CODE);
        expect_quiet();
        send_byte(`PS2_RSHIFT_CODE);
        expect_quiet();
        send_byte(`PS2_BREAK_CODE);
        send_byte(`PS2_RSHIFT_CODE);
        expect_quiet();
        for (i = 0; i < 3; i++)
        begin
            send_byte(quiet_codes[i]);
            expect_quiet();
        end
        end_test("silent sequences", start);

        // bad parity first, then a bad stop bit
        start = errors;
        for (i = 0; i < 2; i++)
        begin
            send_frame(table_code(rand_below(MAP_SIZE)), i == 0, i == 1);
            exp_frame_err = 1'b1;
            poll_status(`STAT_FRAME_ERR_BIT);
            check_read(1'b1, status_word(), "status");
        end
        end_test("frame errors", start);

        start = errors;
        press_key(rand_below(MAP_SIZE));
        press_key(rand_below(MAP_SIZE));
        poll_status(`STAT_READY_BIT);
        check_read(1'b0, exp_char, "data");
        check_read(1'b1, status_word(), "status");
        end_test("overrun", start);

        // failed concurrent assertions of the bound register port checker
        errors = errors + UUT.u_register_port.u_sva.failures;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/ps2_frame_pkg.sv
logic/key_event_pkg.sv
logic/ps2_frame_receiver.sv
logic/scancode_decoder.sv
logic/keymap_translator.sv
logic/key_register_port.sv
logic/ps2_keyboard_top.sv
verification/ps2_keyboard_sva.sv
verification/ps2_keyboard_tb.sv

// ==== Bender.yml ====
package:
  name: ps2_keyboard

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/ps2_frame_pkg.sv
      - logic/key_event_pkg.sv
      - logic/ps2_frame_receiver.sv
      - logic/scancode_decoder.sv
      - logic/keymap_translator.sv
      - logic/key_register_port.sv
      - logic/ps2_keyboard_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - verification/ps2_keyboard_sva.sv
      - verification/ps2_keyboard_tb.sv
